// ==== include/rv_cfg.svh ====
// memory size, console and halt addresses, reset pc of the rv32i core
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// 32-bit words in the unified memory
`define RV_MEM_WORDS 256

// store here to print a word on the console
`define RV_OUT_ADDR 32'd1000

// store here to stop the core
`define RV_HALT_ADDR 32'd1004

// first instruction address
`define RV_RESET_PC 32'd0

`endif

// ==== hw/rv_pkg.sv ====
// rv_pkg: word, opcode, funct, alu and state types, decoded instruction and memory request
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes; only the first five are executed
    typedef enum logic [6:0] {
        OPC_OP      = 7'b0110011,
        OPC_OPIMM   = 7'b0010011,
        OPC_LOAD    = 7'b0000011,
        OPC_STORE   = 7'b0100011,
        OPC_BRANCH  = 7'b1100011,
        OPC_LUI     = 7'b0110111,
        OPC_AUIPC   = 7'b0010111,
        OPC_JALR    = 7'b1100111,
        OPC_MADD    = 7'b1000011,
        OPC_MSUB    = 7'b1000111,
        OPC_NMSUB   = 7'b1001011,
        OPC_NMADD   = 7'b1001111,
        OPC_LOADFP  = 7'b0000111,
        OPC_STOREFP = 7'b0100111,
        OPC_OPFP    = 7'b1010011,
        OPC_OP32    = 7'b0111011,
        OPC_OPIMM32 = 7'b0011011
    } opcode_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_funct_e;

    // encoded as {funct7[5], funct3} of the OP group
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC,
        ST_MEM_WAIT,
        ST_HALTED
    } ctrl_state_e;

    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [2:0] funct3;
        word_t      imm;
        alu_op_e    alu_op;
        logic       use_imm;
        logic       illegal;
    } dec_t;

    typedef struct packed {
        logic  rd_req;
        logic  wr_req;
        word_t addr;
        word_t wr_data;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== hw/rv_decode.sv ====
// rv_decode: instruction fields, immediates, alu operation and illegal flag
`default_nettype none

module rv_decode (
    input  wire rv_pkg::word_t instr,
    output rv_pkg::dec_t       dec
);
    import rv_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      i_imm;
    word_t      s_imm;
    word_t      b_imm;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign i_imm  = {{20{instr[31]}}, instr[31:20]};
    assign s_imm  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    // branch offset already carries the implicit zero bit
    assign b_imm  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        dec.opcode  = opcode_e'(instr[6:0]);
        dec.rd      = instr[11:7];
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.funct3  = funct3;
        dec.imm     = i_imm;
        dec.alu_op  = ALU_ADD;
        dec.use_imm = 1'b0;
        dec.illegal = 1'b0;
        case (opcode_e'(instr[6:0]))
            OPC_OP: begin
                dec.alu_op = alu_op_e'({funct7[5], funct3});
                if (funct7 == 7'b0100000) begin
                    // only sub and sra have the alternate form
                    dec.illegal = !(funct3 == 3'b000 || funct3 == 3'b101);
                end else if (funct7 != 7'b0000000) begin
                    dec.illegal = 1'b1;
                end
            end
            OPC_OPIMM: begin
                dec.alu_op  = alu_op_e'({1'b0, funct3});
                dec.use_imm = 1'b1;
                // shift immediates not supported
                dec.illegal = (funct3 == 3'b001 || funct3 == 3'b101);
            end
            OPC_LOAD: begin
                dec.use_imm = 1'b1;
                dec.illegal = (funct3 != 3'b010);
            end
            OPC_STORE: begin
                dec.imm     = s_imm;
                dec.use_imm = 1'b1;
                dec.illegal = (funct3 != 3'b010);
            end
            OPC_BRANCH: begin
                dec.imm     = b_imm;
                dec.illegal = (funct3 == 3'b010 || funct3 == 3'b011);
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rv_regfile.sv ====
// rv_regfile: 32 x 32-bit registers, two read ports, one write port, x0 tied to zero
`default_nettype none

module rv_regfile (
    input  wire                   clk,
    input  wire                   rst,
    input  wire rv_pkg::reg_idx_t raddr1,
    input  wire rv_pkg::reg_idx_t raddr2,
    output rv_pkg::word_t         rdata1,
    output rv_pkg::word_t         rdata2,
    input  wire                   we,
    input  wire rv_pkg::reg_idx_t waddr,
    input  wire rv_pkg::word_t    wdata
);
    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== hw/rv_alu.sv ====
// rv_alu: add, sub, compares, logic ops, shifts and branch condition
`default_nettype none

module rv_alu (
    input  wire rv_pkg::dec_t  dec,
    input  wire rv_pkg::word_t a,
    input  wire rv_pkg::word_t b_reg,
    output rv_pkg::word_t      result,
    output logic               taken
);
    import rv_pkg::*;

    word_t b;

    assign b = dec.use_imm ? dec.imm : b_reg;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'd0, a < b};
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << b[4:0];
            ALU_SRL:  result = a >> b[4:0];
            // sign bit fills from the left
            ALU_SRA:  result = word_t'($signed(a) >>> b[4:0]);
            default:  result = a + b;
        endcase
    end

    // branches always compare the two registers
    always_comb begin
        case (branch_funct_e'(dec.funct3))
            BR_BEQ:  taken = (a == b_reg);
            BR_BNE:  taken = (a != b_reg);
            BR_BLT:  taken = ($signed(a) < $signed(b_reg));
            BR_BGE:  taken = ($signed(a) >= $signed(b_reg));
            BR_BLTU: taken = (a < b_reg);
            BR_BGEU: taken = (a >= b_reg);
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rv_ctrl.sv ====
// rv_ctrl: control FSM, pc, memory request sequencing, console output and halt
`default_nettype none

`include "rv_cfg.svh"

module rv_ctrl (
    input  wire                   clk,
    input  wire                   rst,
    input  wire rv_pkg::dec_t     dec,
    input  wire rv_pkg::word_t    rs2_val,
    input  wire rv_pkg::word_t    alu_result,
    input  wire                   taken,
    input  wire                   mem_ack,
    input  wire rv_pkg::word_t    mem_rd_data,
    output rv_pkg::mem_req_t      mem_req,
    output logic                  rf_we,
    output rv_pkg::reg_idx_t      rf_waddr,
    output rv_pkg::word_t         rf_wdata,
    output logic                  out_valid,
    output rv_pkg::word_t         out_data,
    output logic                  halted,
    output rv_pkg::word_t         halt_pc
);
    import rv_pkg::*;

    ctrl_state_e state;
    word_t       pc;
    word_t       pc_next;
    word_t       req_addr;
    word_t       req_wdata;
    logic        rd_req_q;
    logic        wr_req_q;
    logic        pend_load;
    reg_idx_t    pend_rd;
    logic        exec_ack;
    logic        store_out;
    logic        store_halt;
    logic        data_access;

    assign exec_ack    = (state == ST_EXEC) && mem_ack;
    // effective address comes straight from the alu sum
    assign store_out   = (dec.opcode == OPC_STORE) && (alu_result == `RV_OUT_ADDR);
    assign store_halt  = (dec.opcode == OPC_STORE) && (alu_result == `RV_HALT_ADDR);
    assign data_access = (state == ST_EXEC) && !dec.illegal &&
                         ((dec.opcode == OPC_LOAD) ||
                          ((dec.opcode == OPC_STORE) && !store_out && !store_halt));
    assign pc_next     = ((state == ST_EXEC) && (dec.opcode == OPC_BRANCH) && taken) ?
                         pc + dec.imm : pc + 32'd4;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_FETCH;
            pc        <= `RV_RESET_PC;
            rd_req_q  <= 1'b0;
            wr_req_q  <= 1'b0;
            out_valid <= 1'b0;
            halted    <= 1'b0;
            pend_load <= 1'b0;
            pend_rd   <= '0;
        end else begin
            rd_req_q  <= 1'b0;
            wr_req_q  <= 1'b0;
            out_valid <= 1'b0;
            case (state)
                ST_FETCH: state <= ST_EXEC;
                ST_EXEC: begin
                    if (mem_ack) begin
                        if (dec.illegal || store_halt) begin
                            state  <= ST_HALTED;
                            halted <= 1'b1;
                        end else if (data_access) begin
                            rd_req_q  <= (dec.opcode == OPC_LOAD);
                            wr_req_q  <= (dec.opcode == OPC_STORE);
                            pend_load <= (dec.opcode == OPC_LOAD);
                            pend_rd   <= dec.rd;
                            state     <= ST_MEM_WAIT;
                        end else begin
                            // alu op, branch or console store
                            out_valid <= store_out;
                            pc        <= pc_next;
                            rd_req_q  <= 1'b1;
                        end
                    end
                end
                ST_MEM_WAIT: begin
                    if (mem_ack) begin
                        pc        <= pc_next;
                        rd_req_q  <= 1'b1;
                        pend_load <= 1'b0;
                        state     <= ST_EXEC;
                    end
                end
                default: state <= ST_HALTED;
            endcase
        end
    end

    // request address and data, captured with the ack that triggers them
    always_ff @(posedge clk) begin
        if (mem_ack) begin
            req_addr  <= data_access ? alu_result : pc_next;
            req_wdata <= rs2_val;
        end
        if (exec_ack && store_out) begin
            out_data <= rs2_val;
        end
    end

    // first fetch comes straight from the fetch state
    always_comb begin
        mem_req.rd_req  = rd_req_q || (state == ST_FETCH);
        mem_req.wr_req  = wr_req_q;
        mem_req.addr    = (state == ST_FETCH) ? pc : req_addr;
        mem_req.wr_data = req_wdata;
    end

    always_comb begin
        rf_we    = 1'b0;
        rf_waddr = dec.rd;
        rf_wdata = alu_result;
        if (exec_ack && !dec.illegal &&
            (dec.opcode == OPC_OP || dec.opcode == OPC_OPIMM)) begin
            rf_we = 1'b1;
        end else if ((state == ST_MEM_WAIT) && mem_ack && pend_load) begin
            rf_we    = 1'b1;
            rf_waddr = pend_rd;
            rf_wdata = mem_rd_data;
        end
    end

    // pc stops on the halting instruction
    assign halt_pc = pc;

    a_req_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.rd_req && mem_req.wr_req));

    a_no_req_halted: assert property (@(posedge clk) disable iff (rst)
        halted |-> !(mem_req.rd_req || mem_req.wr_req));

endmodule

`default_nettype wire

// ==== hw/rv_mem.sv ====
// rv_mem: word memory with reset-time load port and one-cycle acknowledge
`default_nettype none

`include "rv_cfg.svh"

module rv_mem (
    input  wire                   clk,
    input  wire                   rst,
    input  wire rv_pkg::mem_req_t req,
    output logic                  ack,
    output rv_pkg::word_t         rd_data,
    input  wire                   load_en,
    input  wire rv_pkg::word_t    load_addr,
    input  wire rv_pkg::word_t    load_data
);
    import rv_pkg::*;

    localparam int AW = $clog2(`RV_MEM_WORDS);

    word_t          mem [`RV_MEM_WORDS];
    logic [AW-1:0]  req_idx;
    logic [AW-1:0]  load_idx;

    // byte address to word index
    assign req_idx  = req.addr[AW+1:2];
    assign load_idx = load_addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            if (load_en) begin
                mem[load_idx] <= load_data;
            end
        end else if (req.wr_req) begin
            mem[req_idx] <= req.wr_data;
        end
        if (req.rd_req) begin
            rd_data <= mem[req_idx];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= req.rd_req || req.wr_req;
        end
    end

    a_load_in_reset: assert property (@(posedge clk) load_en |-> rst);

endmodule

`default_nettype wire

// ==== hw/rv_top.sv ====
// rv_top: core top level joining control, decoder, register file, alu and memory
`default_nettype none

module rv_top (
    input  wire                clk,
    input  wire                rst,
    input  wire                load_en,
    input  wire rv_pkg::word_t load_addr,
    input  wire rv_pkg::word_t load_data,
    output logic               out_valid,
    output rv_pkg::word_t      out_data,
    output logic               halted,
    output rv_pkg::word_t      halt_pc
);
    import rv_pkg::*;

    mem_req_t mem_req;
    logic     mem_ack;
    word_t    mem_rd_data;
    dec_t     dec;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    alu_result;
    logic     taken;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    rv_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .dec         (dec),
        .rs2_val     (rs2_val),
        .alu_result  (alu_result),
        .taken       (taken),
        .mem_ack     (mem_ack),
        .mem_rd_data (mem_rd_data),
        .mem_req     (mem_req),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .halted      (halted),
        .halt_pc     (halt_pc)
    );

    // instruction word is decoded straight off the memory read port
    rv_decode u_decode (
        .instr (mem_rd_data),
        .dec   (dec)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    rv_alu u_alu (
        .dec    (dec),
        .a      (rs1_val),
        .b_reg  (rs2_val),
        .result (alu_result),
        .taken  (taken)
    );

    rv_mem u_mem (
        .clk       (clk),
        .rst       (rst),
        .req       (mem_req),
        .ack       (mem_ack),
        .rd_data   (mem_rd_data),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

`default_nettype wire

// ==== tb/tb_rv_top.sv ====
// testbench with clock, reset, program load from the vector file, console and halt checks, timeout
`default_nettype none

`include "rv_cfg.svh"

module tb_rv_top;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int LOOP_FACTOR  = 8;
    localparam int QUIET_CYCLES = 8;

    logic  clk;
    logic  rst;
    logic  load_en;
    word_t load_addr;
    word_t load_data;
    logic  out_valid;
    word_t out_data;
    logic  halted;
    word_t halt_pc;

    // vector file contents tagged by program number
    word_t p_addr [$];
    word_t p_data [$];
    int    p_prog [$];
    word_t e_word [$];
    int    e_prog [$];
    word_t h_pc   [$];

    rv_top UUT (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .halted    (halted),
        .halt_pc   (halt_pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_out(input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error (%0d ns): console word 0x%h, expected 0x%h",
                                        $time, got, exp));
        end
    endtask

    task automatic check_halt_pc(input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error (%0d ns): halt pc 0x%h, expected 0x%h",
                                        $time, got, exp));
        end
    endtask

    task automatic check_idle_flags(input logic valid, input logic stop);
        if (valid !== 1'b0 || stop !== 1'b0) begin
            stop_with_failure($sformatf("** Error (%0d ns): out_valid %b halted %b, expected low",
                                        $time, valid, stop));
        end
    endtask

    // reads P addr word lines, E word lines and H pc lines
    task automatic read_vectors();
        int    fd;
        int    n;
        int    prog;
        string line;
        byte   tag;
        word_t a;
        word_t d;
        fd   = $fopen("tb/rv_vectors.txt", "r");
        prog = 0;
        if (fd == 0) begin
            stop_with_failure("cannot open tb/rv_vectors.txt");
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%c %h %h", tag, a, d);
            case (tag)
                "P": begin
                    if (n != 3 || a >= `RV_MEM_WORDS * 4) begin
                        stop_with_failure({"bad program line in vector file: ", line});
                    end
                    p_addr.push_back(a);
                    p_data.push_back(d);
                    p_prog.push_back(prog);
                end
                "E": begin
                    e_word.push_back(a);
                    e_prog.push_back(prog);
                end
                "H": begin
                    h_pc.push_back(a);
                    prog++;
                end
                default: ;
            endcase
        end
        $fclose(fd);
    endtask

    task automatic reset_and_load(input int k);
        int i;
        @(posedge clk);
        rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        // memory only takes load writes while rst is high
        for (i = 0; i < p_addr.size(); i++) begin
            if (p_prog[i] == k) begin
                load_en   <= 1'b1;
                load_addr <= p_addr[i];
                load_data <= p_data[i];
                @(posedge clk);
            end
        end
        load_en <= 1'b0;
        @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic run_program(input int k);
        word_t expected [$];
        int    words;
        int    limit;
        int    cycles;
        int    e_pos;
        words = 0;
        foreach (p_prog[i]) begin
            if (p_prog[i] == k) begin
                words++;
            end
        end
        foreach (e_word[i]) begin
            if (e_prog[i] == k) begin
                expected.push_back(e_word[i]);
            end
        end
        limit  = words * 4 * LOOP_FACTOR + 100;
        cycles = 0;
        e_pos  = 0;
        reset_and_load(k);
        while (halted !== 1'b1) begin
            @(negedge clk);
            cycles++;
            // nothing can complete in the first two cycles
            if (cycles <= 2) begin
                check_idle_flags(out_valid, halted);
            end
            if (out_valid === 1'b1) begin
                if (e_pos >= expected.size()) begin
                    stop_with_failure($sformatf("** Error (%0d ns): extra console word 0x%h",
                                                $time, out_data));
                end
                check_out(out_data, expected[e_pos]);
                e_pos++;
            end
            if (cycles >= limit) begin
                stop_with_failure($sformatf("timeout: program %0d did not halt in %0d cycles",
                                            k, limit));
            end
        end
        if (e_pos != expected.size()) begin
            stop_with_failure($sformatf("program %0d halted after %0d of %0d console words",
                                        k, e_pos, expected.size()));
        end
        check_halt_pc(halt_pc, h_pc[k]);
        // a halted core must stay silent
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (out_valid !== 1'b0 || halted !== 1'b1) begin
                stop_with_failure($sformatf("program %0d changed its outputs after halting", k));
            end
        end
        $display("program %0d halted at 0x%h after %0d console words", k, halt_pc, e_pos);
    endtask

    initial begin
        rst       = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        read_vectors();
        if (h_pc.size() == 0) begin
            stop_with_failure("vector file holds no complete program");
        end
        for (int k = 0; k < h_pc.size(); k++) begin
            run_program(k);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/rv_vectors.txt ====
# P <byte address> <instruction word> loads the program, E <word> is the next console word
# H <pc> is the expected halt pc and closes the program
# program 0 with x1 = -8 and x2 = 10
P 00000000 FF800093 # addi x1, x0, -8
P 00000004 00A00113 # addi x2, x0, 10
P 00000008 002081B3 # add  x3, x1, x2
P 0000000C 3E302423 # sw   x3, 1000(x0)
P 00000010 402081B3 # sub
P 00000014 3E302423
P 00000018 0020A1B3 # slt
P 0000001C 3E302423
P 00000020 0020B1B3 # sltu
P 00000024 3E302423
P 00000028 0020F1B3 # and
P 0000002C 3E302423
P 00000030 0020E1B3 # or
P 00000034 3E302423
P 00000038 0020C1B3 # xor
P 0000003C 3E302423
P 00000040 002091B3 # sll
P 00000044 3E302423
P 00000048 0020D1B3 # srl
P 0000004C 3E302423
P 00000050 4020D1B3 # sra
P 00000054 3E302423
P 00000058 00508193 # addi  x3, x1, 5
P 0000005C 3E302423
P 00000060 FFF0A193 # slti  x3, x1, -1
P 00000064 3E302423
P 00000068 0050B193 # sltiu x3, x1, 5
P 0000006C 3E302423
P 00000070 FFF0C193 # xori  x3, x1, -1
P 00000074 3E302423
P 00000078 1230E193 # ori   x3, x1, 0x123
P 0000007C 3E302423
P 00000080 7F00F193 # andi  x3, x1, 0x7f0
P 00000084 3E302423
P 00000088 00508013 # addi x0, x1, 5
P 0000008C 3E002423 # sw   x0, 1000(x0)
P 00000090 20800213 # addi x4, x0, 520
P 00000094 FE122C23 # sw   x1, -8(x4)
P 00000098 FF822283 # lw   x5, -8(x4)
P 0000009C 3E502423 # sw   x5, 1000(x0)
P 000000A0 00300313 # addi x6, x0, 3
P 000000A4 3E602423 # loop sw x6, 1000(x0)
P 000000A8 FFF30313 # addi x6, x6, -1
P 000000AC FE604CE3 # blt  x0, x6, loop
P 000000B0 00210463 # beq  x2, x2, +8 taken
P 000000B4 00000000 # trap
P 000000B8 FE208EE3 # beq  x1, x2, trap not taken
P 000000BC 00209463 # bne  x1, x2, +8
P 000000C0 00000000
P 000000C4 FE211EE3 # bne  x2, x2, trap
P 000000C8 0020C463 # blt  x1, x2, +8
P 000000CC 00000000
P 000000D0 FE114EE3 # blt  x2, x1, trap
P 000000D4 00115463 # bge  x2, x1, +8
P 000000D8 00000000
P 000000DC FE20DEE3 # bge  x1, x2, trap
P 000000E0 00116463 # bltu x2, x1, +8
P 000000E4 00000000
P 000000E8 FE20EEE3 # bltu x1, x2, trap
P 000000EC 0020F463 # bgeu x1, x2, +8
P 000000F0 00000000
P 000000F4 FE117EE3 # bgeu x2, x1, trap
P 000000F8 3E002623 # sw   x0, 1004(x0) halts
P 000000FC 3E102423 # sw   x1, 1000(x0) never runs
E 00000002 # add
E FFFFFFEE # sub
E 00000001 # slt
E 00000000 # sltu
E 00000008 # and
E FFFFFFFA # or
E FFFFFFF2 # xor
E FFFFE000 # sll
E 003FFFFF # srl
E FFFFFFFF # sra
E FFFFFFFD # addi
E 00000001 # slti
E 00000000 # sltiu
E 00000007 # xori
E FFFFFFFB # ori
E 000007F0 # andi
E 00000000 # x0 stays zero
E FFFFFFF8 # loaded back
E 00000003 # loop
E 00000002
E 00000001
H 000000F8
# program 1 ends in an illegal opcode
P 00000000 00500093 # addi x1, x0, 5
P 00000004 3E102423 # sw   x1, 1000(x0)
P 00000008 00000037 # lui  is not supported
E 00000005
H 00000008

// ==== sim.f ====
+incdir+include
hw/rv_pkg.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_ctrl.sv
hw/rv_mem.sv
hw/rv_top.sv
tb/tb_rv_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rv32i core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_rv_top \
    -f sim.f \
    -o tb_rv_top

./obj_dir/tb_rv_top
